// ==== verif/read_stimulus.txt ====
# C addr len size burst legal / D rdata / E mem_addr byte
# addr, rdata, mem_addr and byte in hex; len, size, burst and legal in decimal
C 00000100 3 2 1 1
D a1b2c3d4
D 55667788
D 99aabbcc
D 0f1e2d3c
E 100 d4
E 105 77
E 10f 0f
C 00000204 3 1 2 1
D ffffbeef
D 0000cafe
D 99991234
D 00005678
E 200 34
E 203 56
E 204 ef
E 207 ca
C 00000102 2 0 0 1
D 00000011
D 00000022
D 00000033
E 101 c3
E 102 33
E 103 a1
C 00000402 1 2 1 0
C 00000400 2 1 2 0
C 00000ff8 3 2 1 0
C 00000ff8 1 2 1 1
D 04030201
D 08070605
E ff8 01
E fff 08

// ==== tb.f ====
common/axi_rd_pkg.sv
axi_rd/lane_bank.sv
axi_rd/ar_issue.sv
axi_rd/beat_steer.sv
hw/apb_ctrl.sv
hw/axi_rd_master.sv
verif/tb_axi_rd_master.sv

// ==== Makefile ====
TOP       ?= tb_axi_rd_master
FILELIST  ?= tb.f
LOG       ?= sim.log
VERILATOR ?= verilator
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: compile run clean

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "TEST RESULT: FAIL" $(LOG); then \
		echo "simulation failed, see $(LOG)"; exit 1; \
	fi
	@if ! grep -q "TEST RESULT: PASS" $(LOG); then \
		echo "simulation ended without a result, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== verif/tb_axi_rd_master.sv ====
`timescale 1ns/1ps

module tb_axi_rd_master;
	import axi_rd_pkg::*;

	logic clk;
	logic resetn;
	apb_req_t apb;
	apb_rsp_t apb_out;
	ar_t ar;
	logic arready;
	r_t r;
	logic rready;

	int unsigned lcg_state = 17;
	int mismatches;
	int failures;
	int ar_count;
	rd_cmd_t exp_cmd;
	bit exp_legal;
	bit cmd_pending;
	logic [data_w-1:0] beat_q[$];

	axi_rd_master u_axi_rd_master (
		.clk     (clk),
		.resetn  (resetn),
		.apb     (apb),
		.apb_out (apb_out),
		.ar      (ar),
		.arready (arready),
		.r       (r),
		.rready  (rready)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	function automatic int unsigned lcg_next(input int unsigned range);
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return (lcg_state >> 16) % range;
	endfunction

	task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] got);
		assert (got === exp) else begin
			$display("mismatch at %0t: %s expected %0h got %0h", $time, name, exp, got);
			mismatches++;
		end
	endtask

	// One APB transfer, setup then access until pready
	task automatic apb_access(input logic [paddr_w-1:0] addr, input logic write,
			input logic [data_w-1:0] wdata, output logic [data_w-1:0] rdata, output logic err);
		int waits;
		waits = 0;
		@(negedge clk);
		apb.psel = 1'b1;
		apb.penable = 1'b0;
		apb.pwrite = write;
		apb.paddr = addr;
		apb.pwdata = wdata;
		@(negedge clk);
		apb.penable = 1'b1;
		#1;
		while (!apb_out.pready && waits < 8) begin
			@(negedge clk);
			waits++;
		end
		assert (apb_out.pready) else begin
			$display("timeout at %0t: pready never rose for APB address %0h", $time, addr);
			failures++;
		end
		// Memory reads take one wait state, everything else none
		check_value("pready wait states", (!write && addr >= mem_base) ? 32'd1 : 32'd0, waits);
		rdata = apb_out.prdata;
		err = apb_out.pslverr;
		@(negedge clk);
		apb.psel = 1'b0;
		apb.penable = 1'b0;
	endtask

	task automatic wait_idle(output logic [data_w-1:0] status);
		logic err;
		int polls;
		polls = 0;
		apb_access(reg_status, 1'b0, '0, status, err);
		while (status[0] && polls < 100) begin
			apb_access(reg_status, 1'b0, '0, status, err);
			polls++;
		end
		assert (!status[0]) else begin
			$display("timeout at %0t: busy did not clear after the read burst", $time);
			failures++;
		end
	endtask

	task automatic run_command();
		logic [data_w-1:0] rdata;
		logic [data_w-1:0] ctrl;
		logic err;
		int ar_before;
		int cycles;
		ar_before = ar_count;
		ctrl = (data_w'(exp_cmd.len) << ctrl_len_lsb) | (data_w'(exp_cmd.size) << ctrl_size_lsb)
			| (data_w'(exp_cmd.burst) << ctrl_burst_lsb);
		apb_access(reg_addr, 1'b1, exp_cmd.addr, rdata, err);
		apb_access(reg_ctrl, 1'b1, ctrl, rdata, err);
		apb_access(reg_start, 1'b1, 32'd1, rdata, err);
		// Second START arrives while the burst is still running
		apb_access(reg_start, 1'b1, 32'd1, rdata, err);
		if (exp_legal) begin
			wait_idle(rdata);
			check_value("status", 32'd0, rdata);
		end else begin
			cycles = 0;
			while (cycles < 16) begin
				@(negedge clk);
				cycles++;
			end
			apb_access(reg_status, 1'b0, '0, rdata, err);
			check_value("status", 32'd2, rdata);
		end
		check_value("ar count", ar_before + (exp_legal ? 1 : 0), ar_count);
		beat_q.delete();
		cmd_pending = 1'b0;
	endtask

	// AXI read slave, answers each AR with the queued beats
	initial begin : slave_model
		int state;
		int ar_delay;
		int gap;
		int beat_idx;
		arready = 1'b0;
		r = '0;
		state = 0;
		ar_delay = 0;
		gap = 0;
		beat_idx = 0;
		forever begin
			@(negedge clk);
			arready = 1'b0;
			r = '0;
			if (state == 0 && resetn && ar.arvalid) begin
				ar_delay = lcg_next(4);
				state = 1;
			end
			if (state == 1) begin
				if (ar_delay == 0) begin
					arready = 1'b1;
					ar_count++;
					check_value("araddr", exp_cmd.addr, ar.cmd.addr);
					check_value("arlen", exp_cmd.len, ar.cmd.len);
					check_value("arsize", exp_cmd.size, ar.cmd.size);
					check_value("arburst", exp_cmd.burst, ar.cmd.burst);
					beat_idx = 0;
					gap = lcg_next(3);
					state = 2;
				end else begin
					ar_delay--;
				end
			end else if (state == 2) begin
				if (gap > 0) begin
					gap--;
				end else if (beat_idx < beat_q.size()) begin
					check_value("rready", 32'd1, rready);
					r.rvalid = 1'b1;
					r.rdata = beat_q[beat_idx];
					r.rlast = (beat_idx == beat_q.size() - 1);
					beat_idx++;
					gap = lcg_next(3);
					if (beat_idx == beat_q.size())
						state = 0;
				end else begin
					state = 0;
				end
			end
		end
	end

	initial begin
		int fd;
		int len;
		int size;
		int burst;
		int legal;
		string tag;
		string skip;
		logic [addr_w-1:0] addr;
		logic [data_w-1:0] data;
		logic [data_w-1:0] rdata;
		logic [7:0] exp_byte;
		logic err;
		apb = '0;
		resetn = 1'b0;
		mismatches = 0;
		failures = 0;
		ar_count = 0;
		exp_cmd = '0;
		cmd_pending = 1'b0;
		repeat (16) @(negedge clk);
		resetn = 1'b1;
		check_value("arvalid", 32'd0, ar.arvalid);
		check_value("rready", 32'd0, rready);

		fd = $fopen("verif/read_stimulus.txt", "r");
		assert (fd != 0) else begin
			$display("could not open the stimulus file verif/read_stimulus.txt");
			failures++;
		end
		while (fd != 0 && $fscanf(fd, "%s", tag) == 1) begin
			if (tag == "C") begin
				if (cmd_pending)
					run_command();
				void'($fscanf(fd, "%h %d %d %d %d", addr, len, size, burst, legal));
				exp_cmd.addr = addr;
				exp_cmd.len = len_w'(len);
				exp_cmd.size = size_e'(size);
				exp_cmd.burst = burst_e'(burst);
				exp_legal = (legal != 0);
				cmd_pending = 1'b1;
			end else if (tag == "D") begin
				void'($fscanf(fd, "%h", data));
				beat_q.push_back(data);
			end else if (tag == "E") begin
				if (cmd_pending)
					run_command();
				void'($fscanf(fd, "%h %h", addr, exp_byte));
				apb_access(mem_base + paddr_w'(addr), 1'b0, '0, rdata, err);
				check_value($sformatf("mem[%0h]", addr), {24'd0, exp_byte}, rdata);
				check_value("pslverr", 32'd0, err);
			end else begin
				void'($fgets(skip, fd));
			end
		end
		if (cmd_pending)
			run_command();
		if (fd != 0)
			$fclose(fd);

		// Memory window and undefined offsets reject writes
		apb_access(mem_base + 13'h010, 1'b1, 32'h55, rdata, err);
		check_value("pslverr", 32'd1, err);
		apb_access(13'h010, 1'b1, 32'h55, rdata, err);
		check_value("pslverr", 32'd1, err);

		$display("checks done: %0d mismatches, %0d other failures", mismatches, failures);
		if (mismatches == 0 && failures == 0) begin
			$display("TEST RESULT: PASS");
		end else begin
			$display("TEST RESULT: FAIL");
		end
		$finish;
	end

endmodule

// ==== hw/axi_rd_master.sv ====
`timescale 1ns/1ps

module axi_rd_master (
	input  logic clk,
	input  logic resetn,
	input  axi_rd_pkg::apb_req_t apb,
	output axi_rd_pkg::apb_rsp_t apb_out,
	output axi_rd_pkg::ar_t ar,
	input  logic arready,
	input  axi_rd_pkg::r_t r,
	output logic rready
);
	import axi_rd_pkg::*;

	logic start;
	logic done;
	rd_cmd_t cmd;
	logic [bank_idx_w-1:0] rd_index;
	logic [lanes-1:0][7:0] rd_data;
	bank_wr_t [lanes-1:0] bank_wr;

	apb_ctrl u_apb_ctrl (
		.clk      (clk),
		.resetn   (resetn),
		.apb      (apb),
		.apb_out  (apb_out),
		.done     (done),
		.start    (start),
		.cmd      (cmd),
		.rd_index (rd_index),
		.rd_data  (rd_data)
	);

	ar_issue u_ar_issue (
		.clk     (clk),
		.resetn  (resetn),
		.start   (start),
		.cmd     (cmd),
		.ar      (ar),
		.arready (arready)
	);

	beat_steer u_beat_steer (
		.clk     (clk),
		.resetn  (resetn),
		.start   (start),
		.cmd     (cmd),
		.r       (r),
		.rready  (rready),
		.done    (done),
		.bank_wr (bank_wr)
	);

	// Byte address a lives in bank a mod 4 at index a / 4
	for (genvar i = 0; i < lanes; i++) begin : g_lane
		lane_bank u_lane_bank (
			.clk      (clk),
			.wr       (bank_wr[i]),
			.rd_index (rd_index),
			.rd_data  (rd_data[i])
		);
	end

endmodule

// ==== hw/apb_ctrl.sv ====
`timescale 1ns/1ps

module apb_ctrl (
	input  logic clk,
	input  logic resetn,
	input  axi_rd_pkg::apb_req_t apb,
	output axi_rd_pkg::apb_rsp_t apb_out,
	input  logic done,
	output logic start,
	output axi_rd_pkg::rd_cmd_t cmd,
	output logic [axi_rd_pkg::bank_idx_w-1:0] rd_index,
	input  logic [axi_rd_pkg::lanes-1:0][7:0] rd_data
);
	import axi_rd_pkg::*;

	logic access;
	logic mem_sel;
	logic mem_rd;
	logic mem_wait;
	logic [1:0] lane_sel;
	logic start_wr;
	logic busy;
	logic error;
	logic legal;
	logic aligned;
	logic size_ok;
	logic burst_ok;
	logic wrap_len_ok;
	logic [mem_aw:0] beats;
	logic [mem_aw:0] burst_bytes;
	logic [mem_aw:0] burst_end;
	logic [data_w-1:0] ctrl_rd;

	assign access = apb.psel && apb.penable;
	assign mem_sel = apb.paddr >= mem_base;
	assign mem_rd = access && !apb.pwrite && mem_sel;
	assign start_wr = access && apb.pwrite && !busy && (apb.paddr == reg_start) && apb.pwdata[0];

	// Command registers are frozen while a burst is running
	always_ff @(posedge clk or negedge resetn) begin
		if (!resetn) begin
			cmd <= '0;
		end else if (access && apb.pwrite && !busy) begin
			if (apb.paddr == reg_addr)
				cmd.addr <= apb.pwdata;
			if (apb.paddr == reg_ctrl) begin
				cmd.len <= apb.pwdata[ctrl_len_lsb +: len_w];
				cmd.size <= size_e'(apb.pwdata[ctrl_size_lsb +: 2]);
				cmd.burst <= burst_e'(apb.pwdata[ctrl_burst_lsb +: 2]);
			end
		end
	end

	assign beats = (mem_aw+1)'(cmd.len) + (mem_aw+1)'(1);
	assign burst_bytes = beats << cmd.size;
	assign burst_end = {1'b0, cmd.addr[mem_aw-1:0]} + burst_bytes;

	always_comb begin
		case (cmd.size)
			size_1: aligned = 1'b1;
			size_2: aligned = !cmd.addr[0];
			size_4: aligned = cmd.addr[1:0] == 2'b00;
			default: aligned = 1'b0;
		endcase
	end

	assign size_ok = cmd.size inside {size_1, size_2, size_4};
	assign burst_ok = cmd.burst inside {burst_fixed, burst_incr, burst_wrap};
	assign wrap_len_ok = (cmd.burst != burst_wrap) || (cmd.len inside {4'd1, 4'd3, 4'd7, 4'd15});
	assign legal = size_ok && burst_ok && aligned && wrap_len_ok && (burst_end <= mem_bytes);

	always_ff @(posedge clk or negedge resetn) begin
		if (!resetn) begin
			start <= 1'b0;
			busy <= 1'b0;
			error <= 1'b0;
		end else begin
			start <= start_wr && legal;
			if (start_wr) begin
				busy <= legal;
				error <= !legal;
			end else if (done) begin
				busy <= 1'b0;
			end
		end
	end

	// One wait state for memory reads while the banks fetch
	always_ff @(posedge clk or negedge resetn) begin
		if (!resetn) begin
			mem_wait <= 1'b0;
		end else begin
			mem_wait <= mem_rd && !mem_wait;
		end
	end

	always_ff @(posedge clk) begin
		if (mem_rd && !mem_wait)
			lane_sel <= apb.paddr[1:0];
	end

	assign rd_index = apb.paddr[bank_idx_w+1:2];

	always_comb begin
		ctrl_rd = '0;
		ctrl_rd[ctrl_len_lsb +: len_w] = cmd.len;
		ctrl_rd[ctrl_size_lsb +: 2] = cmd.size;
		ctrl_rd[ctrl_burst_lsb +: 2] = cmd.burst;
	end

	always_comb begin
		apb_out = '0;
		apb_out.pready = !(mem_rd && !mem_wait);
		if (access) begin
			if (mem_sel) begin
				// Memory window is read only
				apb_out.pslverr = apb.pwrite;
				apb_out.prdata = {{(data_w-8){1'b0}}, rd_data[lane_sel]};
			end else begin
				case (apb.paddr)
					reg_addr: apb_out.prdata = cmd.addr;
					reg_ctrl: apb_out.prdata = ctrl_rd;
					reg_start: apb_out.prdata = '0;
					reg_status: apb_out.prdata = {{(data_w-2){1'b0}}, error, busy};
					default: apb_out.pslverr = 1'b1;
				endcase
			end
		end
	end

	a_penable_needs_psel: assert property (
		@(posedge clk) disable iff (!resetn)
		apb.penable |-> apb.psel
	);

endmodule

// ==== axi_rd/beat_steer.sv ====
`timescale 1ns/1ps

module beat_steer (
	input  logic clk,
	input  logic resetn,
	input  logic start,
	input  axi_rd_pkg::rd_cmd_t cmd,
	input  axi_rd_pkg::r_t r,
	output logic rready,
	output logic done,
	output axi_rd_pkg::bank_wr_t [axi_rd_pkg::lanes-1:0] bank_wr
);
	import axi_rd_pkg::*;

	logic active;
	logic accept;
	logic last_beat;
	logic [len_w-1:0] beat_cnt;
	logic [mem_aw-1:0] beat_addr;
	logic [mem_aw-1:0] next_addr;
	logic [mem_aw-1:0] incr_addr;
	logic [mem_aw-1:0] step;
	logic [mem_aw-1:0] wrap_mask;

	assign rready = active;
	assign accept = r.rvalid && active;
	assign last_beat = beat_cnt == cmd.len;

	// Bytes per beat, and the wrap window minus one
	assign step = mem_aw'(1) << cmd.size;
	assign wrap_mask = ((mem_aw'(cmd.len) + mem_aw'(1)) << cmd.size) - mem_aw'(1);
	assign incr_addr = beat_addr + step;

	always_comb begin
		case (cmd.burst)
			burst_fixed: begin
				next_addr = beat_addr;
			end
			burst_incr: begin
				next_addr = incr_addr;
			end
			burst_wrap: begin
				// Upper bits stay at the boundary base, low bits roll over
				next_addr = (beat_addr & ~wrap_mask) | (incr_addr & wrap_mask);
			end
			default: begin
				next_addr = beat_addr;
			end
		endcase
	end

	always_ff @(posedge clk or negedge resetn) begin
		if (!resetn) begin
			active <= 1'b0;
			done <= 1'b0;
			beat_cnt <= '0;
			beat_addr <= '0;
		end else begin
			done <= accept && last_beat;
			if (start) begin
				active <= 1'b1;
				beat_cnt <= '0;
				beat_addr <= cmd.addr[mem_aw-1:0];
			end else if (accept) begin
				beat_cnt <= beat_cnt + 1'b1;
				beat_addr <= next_addr;
				if (last_beat)
					active <= 1'b0;
			end
		end
	end

	// Bank b takes beat byte j where beat_addr + j lands on bank b
	for (genvar b = 0; b < lanes; b++) begin : g_steer
		logic [1:0] j;
		logic [mem_aw-1:0] byte_addr;

		assign j = 2'(b) - beat_addr[1:0];
		assign byte_addr = beat_addr + mem_aw'(j);
		assign bank_wr[b].en = accept && (mem_aw'(j) < step);
		assign bank_wr[b].index = byte_addr[bank_idx_w+1:2];
		assign bank_wr[b].data = r.rdata[8*j +: 8];
	end

	// Slave must end the burst on exactly the commanded beat count
	a_rlast_on_len: assert property (
		@(posedge clk) disable iff (!resetn)
		accept |-> (r.rlast == last_beat)
	);

endmodule

// ==== axi_rd/ar_issue.sv ====
`timescale 1ns/1ps

module ar_issue (
	input  logic clk,
	input  logic resetn,
	input  logic start,
	input  axi_rd_pkg::rd_cmd_t cmd,
	output axi_rd_pkg::ar_t ar,
	input  logic arready
);

	typedef enum logic {
		ar_idle,
		ar_present
	} ar_state_e;

	ar_state_e state;
	ar_state_e state_next;

	always_ff @(posedge clk or negedge resetn) begin
		if (!resetn) begin
			state <= ar_idle;
		end else begin
			state <= state_next;
		end
	end

	always_comb begin
		state_next = state;
		case (state)
			ar_idle: begin
				if (start)
					state_next = ar_present;
			end
			ar_present: begin
				if (arready)
					state_next = ar_idle;
			end
			default: begin
				state_next = ar_idle;
			end
		endcase
	end

	// Payload is zero outside the presenting state
	always_comb begin
		ar = '0;
		if (state == ar_present) begin
			ar.arvalid = 1'b1;
			ar.cmd = cmd;
		end
	end

	// The controller must hold cmd while the address is waiting
	a_ar_stable: assert property (
		@(posedge clk) disable iff (!resetn)
		ar.arvalid && !arready |=> ar.arvalid && $stable(ar.cmd)
	);

endmodule

// ==== axi_rd/lane_bank.sv ====
`timescale 1ns/1ps

module lane_bank (
	input  logic clk,
	input  axi_rd_pkg::bank_wr_t wr,
	input  logic [axi_rd_pkg::bank_idx_w-1:0] rd_index,
	output logic [7:0] rd_data
);
	import axi_rd_pkg::*;

	logic [7:0] mem [bank_depth];

	always_ff @(posedge clk) begin
		if (wr.en)
			mem[wr.index] <= wr.data;
	end

	// Registered read, data follows the index by one cycle
	always_ff @(posedge clk) begin
		rd_data <= mem[rd_index];
	end

endmodule

// ==== common/axi_rd_pkg.sv ====
package axi_rd_pkg;

	localparam int addr_w = 32;
	localparam int data_w = 32;
	localparam int len_w = 4;
	localparam int lanes = 4;
	localparam int mem_bytes = 4096;
	localparam int mem_aw = $clog2(mem_bytes);
	localparam int bank_depth = 1024;
	localparam int bank_idx_w = 10;
	localparam int paddr_w = 13;

	// APB register map, memory window starts at mem_base
	localparam logic [paddr_w-1:0] reg_addr = 13'h000;
	localparam logic [paddr_w-1:0] reg_ctrl = 13'h004;
	localparam logic [paddr_w-1:0] reg_start = 13'h008;
	localparam logic [paddr_w-1:0] reg_status = 13'h00C;
	localparam logic [paddr_w-1:0] mem_base = 13'h1000;

	// Field positions inside reg_ctrl
	localparam int ctrl_len_lsb = 0;
	localparam int ctrl_size_lsb = 4;
	localparam int ctrl_burst_lsb = 8;

	typedef enum logic [1:0] {
		burst_fixed = 2'd0,
		burst_incr = 2'd1,
		burst_wrap = 2'd2
	} burst_e;

	// Encoded as log2 of the bytes per beat
	typedef enum logic [1:0] {
		size_1 = 2'd0,
		size_2 = 2'd1,
		size_4 = 2'd2
	} size_e;

	typedef struct packed {
		logic [addr_w-1:0] addr;
		logic [len_w-1:0] len;
		size_e size;
		burst_e burst;
	} rd_cmd_t;

	typedef struct packed {
		logic psel;
		logic penable;
		logic pwrite;
		logic [paddr_w-1:0] paddr;
		logic [data_w-1:0] pwdata;
	} apb_req_t;

	typedef struct packed {
		logic [data_w-1:0] prdata;
		logic pready;
		logic pslverr;
	} apb_rsp_t;

	typedef struct packed {
		logic arvalid;
		rd_cmd_t cmd;
	} ar_t;

	typedef struct packed {
		logic rvalid;
		logic [data_w-1:0] rdata;
		logic rlast;
	} r_t;

	typedef struct packed {
		logic en;
		logic [bank_idx_w-1:0] index;
		logic [7:0] data;
	} bank_wr_t;

endpackage
